// ==== src/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    localparam int WORD_W        = 32;
    localparam int NUM_SETS      = 8;
    localparam int IDX_W         = 3;
    localparam int WORDS_PER_BLK = 2;
    localparam int BLKOFF_W      = 1;
    localparam int BYTOFF_W      = 2;
    localparam int TAG_W         = WORD_W - IDX_W - BLKOFF_W - BYTOFF_W;
    // final set visited by the flush walk
    localparam int LAST_IDX      = NUM_SETS - 1;

    typedef logic [WORD_W-1:0] word_t;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [IDX_W-1:0]    idx;
        logic [BLKOFF_W-1:0] blkoff;
        logic [BYTOFF_W-1:0] bytoff;
    } dcache_addr_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        logic  halt;
        word_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic                      hit;
        logic                      valid;
        logic                      dirty;
        logic [TAG_W-1:0]          tag;
        word_t [WORDS_PER_BLK-1:0] data;
    } way_status_t;

    typedef struct packed {
        logic                      en;
        logic                      inval_all;
        logic [IDX_W-1:0]          idx;
        logic [TAG_W-1:0]          tag;
        logic                      valid;
        logic                      dirty;
        logic [WORDS_PER_BLK-1:0]  word_en;
        word_t [WORDS_PER_BLK-1:0] wdata;
    } way_write_t;

    typedef enum logic [3:0] {
        IDLE,
        WB_WORD0,
        WB_WORD1,
        FILL_WORD0,
        FILL_WORD1,
        FLUSH_CHECK,
        FLUSH_WORD0,
        FLUSH_WORD1,
        FLUSHED
    } dcache_state_t;

endpackage

`default_nettype wire

// ==== src/cache_way.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_way (
    input  logic                         CLK,
    input  logic                         n_rst,
    input  logic [dcache_pkg::IDX_W-1:0] lookup_idx,
    input  logic [dcache_pkg::TAG_W-1:0] lookup_tag,
    input  dcache_pkg::way_write_t       wr,
    output dcache_pkg::way_status_t      status
);
    import dcache_pkg::*;

    logic [NUM_SETS-1:0]       valid_q;
    logic [NUM_SETS-1:0]       dirty_q;
    logic [TAG_W-1:0]          tag_q  [NUM_SETS];
    word_t [WORDS_PER_BLK-1:0] data_q [NUM_SETS];

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            for (int i = 0; i < NUM_SETS; i++) begin
                tag_q[i]  <= '0;
                data_q[i] <= '0;
            end
        end else if (wr.inval_all) begin
            // halt drops every block at once, dirty bits stay for the flush walk
            valid_q <= '0;
        end else if (wr.en) begin
            valid_q[wr.idx] <= wr.valid;
            dirty_q[wr.idx] <= wr.dirty;
            tag_q[wr.idx]   <= wr.tag;
            for (int w = 0; w < WORDS_PER_BLK; w++) begin
                if (wr.word_en[w]) begin
                    data_q[wr.idx][w] <= wr.wdata[w];
                end
            end
        end
    end

    // lookup of the addressed frame
    always_comb begin
        status.valid = valid_q[lookup_idx];
        status.dirty = dirty_q[lookup_idx];
        status.tag   = tag_q[lookup_idx];
        status.data  = data_q[lookup_idx];
        status.hit   = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    end

endmodule

`default_nettype wire

// ==== src/dcache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl (
    input  logic                         CLK,
    input  logic                         n_rst,
    input  dcache_pkg::cpu_req_t         cpu_req,
    output logic                         dhit,
    output dcache_pkg::word_t            rdata,
    output logic                         flushed,
    input  dcache_pkg::way_status_t      way0_status,
    input  dcache_pkg::way_status_t      way1_status,
    output logic [dcache_pkg::IDX_W-1:0] lookup_idx,
    output logic [dcache_pkg::TAG_W-1:0] lookup_tag,
    output dcache_pkg::way_write_t       way0_wr,
    output dcache_pkg::way_write_t       way1_wr,
    output dcache_pkg::mem_req_t         mem_req,
    input  logic                         dwait,
    input  dcache_pkg::word_t            rdata_mem
);
    import dcache_pkg::*;

    dcache_state_t       state;
    dcache_state_t       next_state;
    logic [NUM_SETS-1:0] lru;
    logic [NUM_SETS-1:0] next_lru;
    logic [IDX_W-1:0]    flush_idx;
    logic [IDX_W-1:0]    next_flush_idx;
    mem_req_t            next_mem_req;

    dcache_addr_t cpu_addr;
    logic         req_valid;
    logic         any_hit;
    logic         hit_way;
    logic         victim;
    logic         flush_way;
    way_status_t  hit_st;
    way_status_t  victim_st;
    way_status_t  flush_st;
    way_write_t   wr_cmd;
    logic [1:0]   wr_sel;

    function automatic word_t blk_addr(input logic [TAG_W-1:0]    tag,
                                       input logic [IDX_W-1:0]    idx,
                                       input logic [BLKOFF_W-1:0] blkoff);
        dcache_addr_t a;
        a.tag    = tag;
        a.idx    = idx;
        a.blkoff = blkoff;
        a.bytoff = '0;
        return word_t'(a);
    endfunction

    assign cpu_addr  = dcache_addr_t'(cpu_req.addr);
    assign req_valid = cpu_req.ren || cpu_req.wen;
    assign any_hit   = way0_status.hit || way1_status.hit;
    assign hit_way   = !way0_status.hit;
    assign hit_st    = hit_way ? way1_status : way0_status;
    assign victim    = lru[cpu_addr.idx];
    assign victim_st = victim ? way1_status : way0_status;
    // way0 stays dirty until its own writeback has finished
    assign flush_way = !way0_status.dirty;
    assign flush_st  = flush_way ? way1_status : way0_status;

    assign lookup_tag = cpu_addr.tag;
    assign lookup_idx = (state inside {FLUSH_CHECK, FLUSH_WORD0, FLUSH_WORD1}) ?
                        flush_idx : cpu_addr.idx;

    assign dhit    = (state == IDLE) && !cpu_req.halt && req_valid && any_hit;
    assign rdata   = hit_st.data[cpu_addr.blkoff];
    assign flushed = (state == FLUSHED);

    assign way0_wr = wr_sel[0] ? wr_cmd : '0;
    assign way1_wr = wr_sel[1] ? wr_cmd : '0;

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            state     <= IDLE;
            lru       <= '0;
            flush_idx <= '0;
            mem_req   <= '0;
        end else begin
            state     <= next_state;
            lru       <= next_lru;
            flush_idx <= next_flush_idx;
            mem_req   <= next_mem_req;
        end
    end

    always_comb begin
        next_state     = state;
        next_lru       = lru;
        next_flush_idx = flush_idx;
        next_mem_req   = mem_req;
        wr_cmd         = '0;
        wr_sel         = 2'b00;

        case (state)
            IDLE: begin
                if (cpu_req.halt) begin
                    wr_cmd.inval_all = 1'b1;
                    wr_sel           = 2'b11;
                    next_flush_idx   = '0;
                    next_mem_req     = '0;
                    next_state       = FLUSH_CHECK;
                end else if (req_valid && any_hit) begin
                    next_lru[cpu_addr.idx] = !hit_way;
                    if (cpu_req.wen) begin
                        wr_cmd.en                       = 1'b1;
                        wr_cmd.idx                      = cpu_addr.idx;
                        wr_cmd.tag                      = cpu_addr.tag;
                        wr_cmd.valid                    = 1'b1;
                        wr_cmd.dirty                    = 1'b1;
                        wr_cmd.word_en[cpu_addr.blkoff] = 1'b1;
                        wr_cmd.wdata                    = {2{cpu_req.wdata}};
                        wr_sel[hit_way]                 = 1'b1;
                    end
                end else if (req_valid) begin
                    if (victim_st.dirty) begin
                        next_mem_req.wen   = 1'b1;
                        next_mem_req.addr  = blk_addr(victim_st.tag, cpu_addr.idx, 1'b0);
                        next_mem_req.wdata = victim_st.data[0];
                        next_state         = WB_WORD0;
                    end else begin
                        next_mem_req.ren  = 1'b1;
                        next_mem_req.addr = blk_addr(cpu_addr.tag, cpu_addr.idx, 1'b0);
                        next_state        = FILL_WORD0;
                    end
                end
            end
            WB_WORD0: begin
                if (!dwait) begin
                    next_mem_req.addr  = blk_addr(victim_st.tag, cpu_addr.idx, 1'b1);
                    next_mem_req.wdata = victim_st.data[1];
                    next_state         = WB_WORD1;
                end
            end
            WB_WORD1: begin
                if (!dwait) begin
                    next_mem_req.wen   = 1'b0;
                    next_mem_req.ren   = 1'b1;
                    next_mem_req.addr  = blk_addr(cpu_addr.tag, cpu_addr.idx, 1'b0);
                    next_mem_req.wdata = '0;
                    next_state         = FILL_WORD0;
                end
            end
            FILL_WORD0: begin
                if (!dwait) begin
                    // word0 lands now, frame stays invalid until word1
                    wr_cmd.en         = 1'b1;
                    wr_cmd.idx        = cpu_addr.idx;
                    wr_cmd.tag        = cpu_addr.tag;
                    wr_cmd.word_en[0] = 1'b1;
                    wr_cmd.wdata[0]   = rdata_mem;
                    wr_sel[victim]    = 1'b1;
                    next_mem_req.addr = blk_addr(cpu_addr.tag, cpu_addr.idx, 1'b1);
                    next_state        = FILL_WORD1;
                end
            end
            FILL_WORD1: begin
                if (!dwait) begin
                    wr_cmd.en         = 1'b1;
                    wr_cmd.idx        = cpu_addr.idx;
                    wr_cmd.tag        = cpu_addr.tag;
                    wr_cmd.valid      = 1'b1;
                    wr_cmd.dirty      = cpu_req.wen;
                    wr_cmd.word_en[1] = 1'b1;
                    wr_cmd.wdata[1]   = rdata_mem;
                    // merge the store word over the filled block
                    if (cpu_req.wen) begin
                        wr_cmd.word_en[cpu_addr.blkoff] = 1'b1;
                        wr_cmd.wdata[cpu_addr.blkoff]   = cpu_req.wdata;
                    end
                    wr_sel[victim]         = 1'b1;
                    next_lru[cpu_addr.idx] = !victim;
                    next_mem_req           = '0;
                    next_state             = IDLE;
                end
            end
            FLUSH_CHECK: begin
                if (way0_status.dirty || way1_status.dirty) begin
                    next_mem_req.wen   = 1'b1;
                    next_mem_req.addr  = blk_addr(flush_st.tag, flush_idx, 1'b0);
                    next_mem_req.wdata = flush_st.data[0];
                    next_state         = FLUSH_WORD0;
                end else if (flush_idx == IDX_W'(LAST_IDX)) begin
                    next_state = FLUSHED;
                end else begin
                    next_flush_idx = flush_idx + 1'b1;
                end
            end
            FLUSH_WORD0: begin
                if (!dwait) begin
                    next_mem_req.addr  = blk_addr(flush_st.tag, flush_idx, 1'b1);
                    next_mem_req.wdata = flush_st.data[1];
                    next_state         = FLUSH_WORD1;
                end
            end
            FLUSH_WORD1: begin
                if (!dwait) begin
                    // clean the frame, same index is checked again
                    wr_cmd.en         = 1'b1;
                    wr_cmd.idx        = flush_idx;
                    wr_cmd.tag        = flush_st.tag;
                    wr_cmd.valid      = flush_st.valid;
                    wr_sel[flush_way] = 1'b1;
                    next_mem_req      = '0;
                    next_state        = FLUSH_CHECK;
                end
            end
            FLUSHED: begin
                next_mem_req = '0;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/dcache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
    input  logic                 CLK,
    input  logic                 n_rst,
    input  dcache_pkg::cpu_req_t cpu_req,
    output logic                 dhit,
    output dcache_pkg::word_t    rdata,
    output logic                 flushed,
    output dcache_pkg::mem_req_t mem_req,
    input  logic                 dwait,
    input  dcache_pkg::word_t    rdata_mem
);
    import dcache_pkg::*;

    logic [IDX_W-1:0] lookup_idx;
    logic [TAG_W-1:0] lookup_tag;
    way_status_t      way0_status;
    way_status_t      way1_status;
    way_write_t       way0_wr;
    way_write_t       way1_wr;

    cache_way way0 (
        .CLK        (CLK),
        .n_rst      (n_rst),
        .lookup_idx (lookup_idx),
        .lookup_tag (lookup_tag),
        .wr         (way0_wr),
        .status     (way0_status)
    );

    cache_way way1 (
        .CLK        (CLK),
        .n_rst      (n_rst),
        .lookup_idx (lookup_idx),
        .lookup_tag (lookup_tag),
        .wr         (way1_wr),
        .status     (way1_status)
    );

    dcache_ctrl ctrl (
        .CLK         (CLK),
        .n_rst       (n_rst),
        .cpu_req     (cpu_req),
        .dhit        (dhit),
        .rdata       (rdata),
        .flushed     (flushed),
        .way0_status (way0_status),
        .way1_status (way1_status),
        .lookup_idx  (lookup_idx),
        .lookup_tag  (lookup_tag),
        .way0_wr     (way0_wr),
        .way1_wr     (way1_wr),
        .mem_req     (mem_req),
        .dwait       (dwait),
        .rdata_mem   (rdata_mem)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic CLK,
    output logic n_rst
);
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 16;

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    // release on a rising edge, after the flops have sampled it low
    initial begin
        n_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        n_rst <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/dcache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int          NUM_REQS        = 300;
    localparam int          WATCHDOG_CYCLES = NUM_REQS * 20 + 200;
    localparam int          MEM_WORDS       = 64;
    localparam logic [31:0] SEED            = 32'd69922;

    logic        CLK;
    logic        n_rst;
    cpu_req_t    cpu_req;
    logic        dhit;
    word_t       rdata;
    logic        flushed;
    mem_req_t    mem_req;
    logic        dwait = 1'b0;
    word_t       rdata_mem;

    word_t       mem_array [MEM_WORDS];
    word_t       model_mem [MEM_WORDS];
    logic [31:0] stim_lfsr  = SEED;
    logic [31:0] resp_lfsr  = SEED;
    logic [31:0] wait_bits;
    logic [1:0]  wait_left  = '0;
    logic        stall_seen = 1'b0;
    mem_req_t    held_req;

    tb_clock_gen clk_gen (
        .CLK   (CLK),
        .n_rst (n_rst)
    );

    dcache_top dut0 (
        .CLK       (CLK),
        .n_rst     (n_rst),
        .cpu_req   (cpu_req),
        .dhit      (dhit),
        .rdata     (rdata),
        .flushed   (flushed),
        .mem_req   (mem_req),
        .dwait     (dwait),
        .rdata_mem (rdata_mem)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(inout logic [31:0] state, input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits  = {bits[30:0], state[0]};
            state = lfsr_step(state);
        end
    endtask

    task automatic check_eq(input string name, input logic [65:0] got,
                            input logic [65:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic issue_request(input logic is_write, input logic [5:0] widx,
                                 input word_t wval, input logic expect_hit);
        @(posedge CLK);
        cpu_req <= '{ren: !is_write, wen: is_write, halt: 1'b0,
                     addr: word_t'({widx, 2'b00}), wdata: wval};
        @(negedge CLK);
        if (expect_hit) begin
            check_eq("dhit", dhit, 1'b1);
            check_eq("mem_req.ren", mem_req.ren, 1'b0);
            check_eq("mem_req.wen", mem_req.wen, 1'b0);
        end
        while (!dhit) begin
            @(negedge CLK);
        end
        if (is_write) begin
            model_mem[widx] = wval;
        end else begin
            check_eq("rdata", rdata, model_mem[widx]);
        end
    endtask

    // responder read data follows the held request
    assign rdata_mem = mem_array[mem_req.addr[7:2]];

    always @(posedge CLK) begin
        if (!n_rst) begin
            dwait     <= 1'b0;
            wait_left <= '0;
        end else if (mem_req.ren || mem_req.wen) begin
            check_eq("mem_req.addr[31:8]", mem_req.addr[31:8], '0);
            if (!dwait) begin
                if (mem_req.wen) begin
                    mem_array[mem_req.addr[7:2]] <= mem_req.wdata;
                end
                // wait length for the next access
                take_bits(resp_lfsr, 2, wait_bits);
                wait_left <= wait_bits[1:0];
                dwait     <= (wait_bits[1:0] != 2'd0);
            end else begin
                wait_left <= wait_left - 2'd1;
                dwait     <= (wait_left != 2'd1);
            end
        end
    end

    // stalled request must not move
    always @(negedge CLK) begin
        if (stall_seen) begin
            check_eq("mem_req", mem_req, held_req);
        end
        stall_seen = n_rst && (mem_req.ren || mem_req.wen) && dwait;
        held_req   = mem_req;
    end

    initial begin : stimulus
        int          issued;
        logic [31:0] bits;
        logic        is_write;
        logic [5:0]  widx;
        word_t       wval;
        cpu_req = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_array[i] = (word_t'(i) * 32'h9E37_79B9) ^ 32'h5A5A_0000;
            model_mem[i] = mem_array[i];
        end
        @(posedge n_rst);
        @(negedge CLK);
        check_eq("mem_req.ren", mem_req.ren, 1'b0);
        check_eq("mem_req.wen", mem_req.wen, 1'b0);
        check_eq("dhit", dhit, 1'b0);
        check_eq("flushed", flushed, 1'b0);

        issued = 0;
        while (issued < NUM_REQS) begin
            take_bits(stim_lfsr, 1, bits);
            is_write = bits[0];
            take_bits(stim_lfsr, 6, bits);
            widx = bits[5:0];
            take_bits(stim_lfsr, 32, bits);
            wval = bits;
            issue_request(is_write, widx, wval, 1'b0);
            issued++;
            // sometimes read the other word of the same block
            take_bits(stim_lfsr, 2, bits);
            if (bits[1:0] == 2'b00 && issued < NUM_REQS) begin
                issue_request(1'b0, widx ^ 6'd1, wval, 1'b1);
                issued++;
            end
        end

        @(posedge CLK);
        cpu_req <= '{ren: 1'b0, wen: 1'b0, halt: 1'b1, addr: '0, wdata: '0};
        @(negedge CLK);
        while (!flushed) begin
            @(negedge CLK);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_eq($sformatf("mem[%0d]", i), mem_array[i], model_mem[i]);
        end
        repeat (20) begin
            @(negedge CLK);
            check_eq("flushed", flushed, 1'b1);
            check_eq("mem_req.ren", mem_req.ren, 1'b0);
            check_eq("mem_req.wen", mem_req.wen, 1'b0);
        end
        $display("=== PASS ===");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timeout after %0d cycles with the controller in state %s",
                 WATCHDOG_CYCLES, dut0.ctrl.state.name());
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== sources.f ====
src/dcache_pkg.sv
src/cache_way.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verif/tb_clock_gen.sv
verif/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - src/dcache_pkg.sv
  - src/cache_way.sv
  - src/dcache_ctrl.sv
  - src/dcache_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/dcache_tb.sv
